// File: timer_bank_stim.txt
# Records: C op ch data | W idle_cycles | R sel ch expected_rd_data | I expected_irq
# Ops: 1 rollover 2 enable 3 disable 4 clear 5 ack 6 mask; sel: 0 count 1 status
# Reset values
R 0 0 0
R 0 1 0
R 0 2 0
R 0 3 0
R 1 0 0
I 0
# Channel 0 rolls over at 3
C 1 0 3
C 2 0 0
R 0 0 0
R 0 0 1
R 0 0 2
R 0 0 3
R 0 0 1
R 0 0 2
R 1 0 1
I 0
# Clear then disable
C 4 0 0
R 0 0 2
R 0 0 0
R 0 0 1
R 0 0 2
C 3 0 0
W 3
R 0 0 1
W 2
R 0 0 1
R 1 0 1
# Ack while idle clears the event
C 5 0 0
R 1 0 1
R 1 0 0
# Ack on the same edge as a rollover keeps the event
C 2 0 0
R 0 0 1
R 0 0 2
R 0 0 3
R 1 0 1
C 5 0 0
R 1 0 1
R 1 0 1
R 1 0 1
# Masking
I 0
C 3 0 0
C 6 0 1
W 1
I 0
W 1
I 1
C 5 0 0
W 2
I 1
W 1
I 0
R 1 0 0
# Channels 1 and 2 together, channel 4 does not exist
C 1 1 2
C 1 2 5
C 2 4 0
C 2 1 0
C 2 2 0
R 0 1 1
R 0 2 1
R 0 1 1
R 1 0 2
R 0 2 4
R 0 2 5
R 1 0 6
R 0 3 0
R 0 1 1
R 0 2 4
I 0
C 4 4 0
C 3 4 0
R 0 2 2
R 0 1 2
W 1
C 5 2 0
R 1 0 6
R 1 0 2
R 0 3 0
I 0
R 0 0 1

// File: timer_bank.f
timer_bank_pkg.sv
flex_counter.sv
timer_config.sv
rollover_collector.sv
timer_bank.sv
tb_timer_bank.sv

// File: run_sim.sh
#!/bin/sh
# Build the timer bank testbench with Verilator, run it and scan the log

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_timer_bank -f timer_bank.f -o tb_timer_bank \
    && ./obj_dir/tb_timer_bank | tee sim.log \
    && grep -qx "All tests passed" sim.log \
    && echo "Simulation run passed" \
    || { echo "Simulation run failed"; exit 1; }

// File: tb_timer_bank.sv
`timescale 1ns/10ps
`default_nettype none

module tb_timer_bank;

    localparam int CLK_PERIOD = 100;
    localparam     STIM_FILE  = "timer_bank_stim.txt";

    // DUT ports at the widths of the default parameters
    logic                    tb_clk;
    logic                    rst_n;
    logic                    cmd_valid;
    timer_bank_pkg::cmd_op_t cmd_op;
    logic [2:0]              cmd_ch;
    logic [3:0]              cmd_data;
    timer_bank_pkg::rd_sel_t rd_sel;
    logic [2:0]              rd_ch;
    logic [3:0]              rd_data;
    logic                    irq;

    // Run bookkeeping
    int num_lines    = 0;
    int num_checks   = 0;
    int read_errors  = 0;
    int irq_errors   = 0;
    int other_errors = 0;

    timer_bank dut0 (
        .tb_clk    (tb_clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_ch    (cmd_ch),
        .cmd_data  (cmd_data),
        .rd_sel    (rd_sel),
        .rd_ch     (rd_ch),
        .rd_data   (rd_data),
        .irq       (irq)
    );

    // 100 ns clock
    initial begin
        tb_clk = 1'b0;
        forever #(CLK_PERIOD / 2) tb_clk = ~tb_clk;
    end

    // ******************************
    // Stimulus helpers
    // ******************************

    // One command strobe held for a single cycle
    task automatic drive_command(input int op, input int ch, input int data);
        cmd_valid = 1'b1;
        cmd_op    = timer_bank_pkg::cmd_op_t'(3'(op));
        cmd_ch    = 3'(ch);
        cmd_data  = 4'(data);
        @(negedge tb_clk);
        cmd_valid = 1'b0;
        cmd_op    = timer_bank_pkg::CMD_NOP;
    endtask

    task automatic wait_idle(input int cycles);
        repeat (cycles) @(negedge tb_clk);
    endtask

    // Read data compared one cycle after the select is set
    task automatic check_read(input int sel, input int ch, input int expected);
        rd_sel = timer_bank_pkg::rd_sel_t'(1'(sel));
        rd_ch  = 3'(ch);
        @(negedge tb_clk);
        num_checks++;
        assert (rd_data == 4'(expected)) else begin
            read_errors++;
            $display("error at %0t: read sel %0d ch %0d gave %0d, expected %0d",
                     $time, sel, ch, rd_data, expected);
        end
    endtask

    // Irq compared at the current falling edge
    task automatic check_irq(input int expected);
        num_checks++;
        assert (irq == 1'(expected)) else begin
            irq_errors++;
            $display("error at %0t: irq is %0d, expected %0d", $time, irq, expected);
        end
    endtask

    task automatic report_bad_record(input logic [7:0] kind);
        other_errors++;
        $display("Stimulus record %s has missing or unreadable fields", kind);
    endtask

    // Line count sets the watchdog budget
    task automatic count_stim_lines(output int lines);
        int               fd;
        logic [8*128-1:0] line_buf;
        lines = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line_buf, fd) != 0) begin
                lines++;
            end
            $fclose(fd);
        end
    endtask

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        int               fd;
        int               code;
        int               f_a;
        int               f_b;
        int               f_c;
        logic [7:0]       kind;
        logic [8*128-1:0] line_buf;
        // All inputs idle while reset is held
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = timer_bank_pkg::CMD_NOP;
        cmd_ch    = '0;
        cmd_data  = '0;
        rd_sel    = timer_bank_pkg::RD_COUNT;
        rd_ch     = '0;
        count_stim_lines(num_lines);
        repeat (2) @(negedge tb_clk);
        rst_n = 1'b1;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the stimulus file %s", STIM_FILE);
        end else begin
            // One record per pass with the kind letter first
            while ($fscanf(fd, "%s", kind) == 1) begin
                case (kind)
                    "C": begin
                        code = $fscanf(fd, "%d %d %d", f_a, f_b, f_c);
                        if (code == 3) begin
                            drive_command(f_a, f_b, f_c);
                        end else begin
                            report_bad_record(kind);
                        end
                    end
                    "W": begin
                        code = $fscanf(fd, "%d", f_a);
                        if (code == 1) begin
                            wait_idle(f_a);
                        end else begin
                            report_bad_record(kind);
                        end
                    end
                    "R": begin
                        code = $fscanf(fd, "%d %d %d", f_a, f_b, f_c);
                        if (code == 3) begin
                            check_read(f_a, f_b, f_c);
                        end else begin
                            report_bad_record(kind);
                        end
                    end
                    "I": begin
                        code = $fscanf(fd, "%d", f_a);
                        if (code == 1) begin
                            check_irq(f_a);
                        end else begin
                            report_bad_record(kind);
                        end
                    end
                    "#": begin
                        // Rest of a comment line is skipped
                        code = $fgets(line_buf, fd);
                    end
                    default: begin
                        other_errors++;
                        $display("Unknown record kind %s in the stimulus file", kind);
                    end
                endcase
            end
            $fclose(fd);
        end
        $display("Checks: %0d, read errors: %0d, irq errors: %0d, other errors: %0d",
                 num_checks, read_errors, irq_errors, other_errors);
        if (read_errors + irq_errors + other_errors == 0 && num_checks > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // ******************************
    // Watchdog
    // ******************************

    // Budget of 20 cycles per stimulus line plus a fixed margin
    initial begin
        wait (num_lines > 0);
        #(num_lines * 20 * CLK_PERIOD + 100 * CLK_PERIOD);
        $display("Timeout: the stimulus sequence did not finish in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: timer_bank.sv
`timescale 1ns/10ps
`default_nettype none

module timer_bank #(
    parameter  int NUM_CHANNELS = 4,
    parameter  int NUM_CNT_BITS = 4,
    // Channel numbers can point past the last channel
    localparam int CH_BITS      = $clog2(NUM_CHANNELS + 1),
    localparam int RD_BITS      = (NUM_CNT_BITS > NUM_CHANNELS) ? NUM_CNT_BITS
                                                               : NUM_CHANNELS
) (
    input  wire logic                     tb_clk,
    input  wire logic                     rst_n,
    // Command port, one strobe per command
    input  wire logic                     cmd_valid,
    input  wire timer_bank_pkg::cmd_op_t  cmd_op,
    input  wire logic [CH_BITS-1:0]       cmd_ch,
    input  wire logic [NUM_CNT_BITS-1:0]  cmd_data,
    // Read port
    input  wire timer_bank_pkg::rd_sel_t  rd_sel,
    input  wire logic [CH_BITS-1:0]       rd_ch,
    output logic      [RD_BITS-1:0]       rd_data,
    output logic                          irq
);

    // Settings from the decoder, one slice per channel
    logic [NUM_CHANNELS*NUM_CNT_BITS-1:0] rollover_val;
    logic [NUM_CHANNELS-1:0]              count_enable;
    logic [NUM_CHANNELS-1:0]              clear;
    logic [NUM_CHANNELS-1:0]              ack;
    logic [NUM_CHANNELS-1:0]              irq_mask;
    // Counter results toward the collector
    logic [NUM_CHANNELS*NUM_CNT_BITS-1:0] count_out;
    logic [NUM_CHANNELS-1:0]              rollover_flag;

    // ******************************
    // Command decoder
    // ******************************
    timer_config #(
        .NUM_CHANNELS (NUM_CHANNELS),
        .NUM_CNT_BITS (NUM_CNT_BITS)
    ) u_config (
        .tb_clk       (tb_clk),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .cmd_ch       (cmd_ch),
        .cmd_data     (cmd_data),
        .rollover_val (rollover_val),
        .count_enable (count_enable),
        .clear        (clear),
        .ack          (ack),
        .irq_mask     (irq_mask)
    );

    // ******************************
    // Counter per channel
    // ******************************
    for (genvar i = 0; i < NUM_CHANNELS; i++) begin : g_channel
        flex_counter #(
            .NUM_CNT_BITS  (NUM_CNT_BITS)
        ) u_counter (
            .tb_clk        (tb_clk),
            .rst_n         (rst_n),
            .clear         (clear[i]),
            .count_enable  (count_enable[i]),
            .rollover_val  (rollover_val[i*NUM_CNT_BITS +: NUM_CNT_BITS]),
            .count_out     (count_out[i*NUM_CNT_BITS +: NUM_CNT_BITS]),
            .rollover_flag (rollover_flag[i])
        );
    end

    // ******************************
    // Events, interrupt and read back
    // ******************************
    rollover_collector #(
        .NUM_CHANNELS  (NUM_CHANNELS),
        .NUM_CNT_BITS  (NUM_CNT_BITS)
    ) u_collector (
        .tb_clk        (tb_clk),
        .rst_n         (rst_n),
        .count_out     (count_out),
        .rollover_flag (rollover_flag),
        .ack           (ack),
        .irq_mask      (irq_mask),
        .rd_sel        (rd_sel),
        .rd_ch         (rd_ch),
        .rd_data       (rd_data),
        .irq           (irq)
    );

endmodule

`default_nettype wire

// File: rollover_collector.sv
`timescale 1ns/10ps
`default_nettype none

module rollover_collector #(
    parameter  int NUM_CHANNELS = 4,
    parameter  int NUM_CNT_BITS = 4,
    // Same channel index width as the command side
    localparam int CH_BITS      = $clog2(NUM_CHANNELS + 1),
    // Read data fits both a count and the status vector
    localparam int RD_BITS      = (NUM_CNT_BITS > NUM_CHANNELS) ? NUM_CNT_BITS
                                                               : NUM_CHANNELS
) (
    input  wire logic                                 tb_clk,
    input  wire logic                                 rst_n,
    input  wire logic [NUM_CHANNELS*NUM_CNT_BITS-1:0] count_out,
    input  wire logic [NUM_CHANNELS-1:0]              rollover_flag,
    input  wire logic [NUM_CHANNELS-1:0]              ack,
    input  wire logic [NUM_CHANNELS-1:0]              irq_mask,
    input  wire timer_bank_pkg::rd_sel_t              rd_sel,
    input  wire logic [CH_BITS-1:0]                   rd_ch,
    output logic [RD_BITS-1:0]                        rd_data,
    output logic                                      irq
);

    // One sticky event bit per channel
    logic [NUM_CHANNELS-1:0] sticky;
    logic [NUM_CHANNELS-1:0] next_sticky;
    // Events that are allowed to interrupt
    logic [NUM_CHANNELS-1:0] masked_events;

    // ******************************
    // Sticky event bits
    // ******************************

    // Ack clears the bit unless a new flag arrives on the same edge
    assign next_sticky = (sticky & ~ack) | rollover_flag;

    always_ff @(posedge tb_clk) begin
        if (!rst_n) begin
            sticky <= '0;
        end else begin
            sticky <= next_sticky;
        end
    end

    // ******************************
    // Interrupt
    // ******************************
    assign masked_events = sticky & irq_mask;

    // Registered OR that trails the sticky bits by one cycle
    always_ff @(posedge tb_clk) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= |masked_events;
        end
    end

    // ******************************
    // Read mux
    // ******************************
    always_comb begin
        // Unknown channel reads as zero
        rd_data = '0;
        case (rd_sel)
            timer_bank_pkg::RD_COUNT: begin
                for (int i = 0; i < NUM_CHANNELS; i++) begin
                    if (rd_ch == CH_BITS'(i)) begin
                        rd_data = RD_BITS'(count_out[i*NUM_CNT_BITS +: NUM_CNT_BITS]);
                    end
                end
            end
            timer_bank_pkg::RD_STATUS: begin
                // Status is zero extended up to the read width
                rd_data = RD_BITS'(sticky);
            end
            default: begin
                rd_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: timer_config.sv
`timescale 1ns/10ps
`default_nettype none

module timer_config #(
    parameter  int NUM_CHANNELS = 4,
    parameter  int NUM_CNT_BITS = 4,
    // Room for one out of range channel number
    localparam int CH_BITS      = $clog2(NUM_CHANNELS + 1)
) (
    input  wire logic                                 tb_clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 cmd_valid,
    input  wire timer_bank_pkg::cmd_op_t              cmd_op,
    input  wire logic [CH_BITS-1:0]                   cmd_ch,
    input  wire logic [NUM_CNT_BITS-1:0]              cmd_data,
    output logic [NUM_CHANNELS*NUM_CNT_BITS-1:0]      rollover_val,
    output logic [NUM_CHANNELS-1:0]                   count_enable,
    output logic [NUM_CHANNELS-1:0]                   clear,
    output logic [NUM_CHANNELS-1:0]                   ack,
    output logic [NUM_CHANNELS-1:0]                   irq_mask
);

    // Command as captured on the command edge
    logic                     cmd_valid_q;
    timer_bank_pkg::cmd_op_t  cmd_op_q;
    logic [CH_BITS-1:0]       cmd_ch_q;
    logic [NUM_CNT_BITS-1:0]  cmd_data_q;
    // One hot channel select of the captured command
    logic [NUM_CHANNELS-1:0]  ch_sel;

    // ******************************
    // Command capture
    // ******************************

    // Strobe of the captured command
    always_ff @(posedge tb_clk) begin
        if (!rst_n) begin
            cmd_valid_q <= 1'b0;
        end else begin
            cmd_valid_q <= cmd_valid;
        end
    end

    // Payload of the command
    always_ff @(posedge tb_clk) begin
        cmd_op_q   <= cmd_op;
        cmd_ch_q   <= cmd_ch;
        cmd_data_q <= cmd_data;
    end

    // Out of range channel numbers match no bit
    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            ch_sel[i] = cmd_valid_q && (cmd_ch_q == CH_BITS'(i));
        end
    end

    // ******************************
    // Per channel settings
    // ******************************
    always_ff @(posedge tb_clk) begin
        if (!rst_n) begin
            rollover_val <= '0;
            count_enable <= '0;
            irq_mask     <= '0;
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                if (ch_sel[i]) begin
                    case (cmd_op_q)
                        timer_bank_pkg::CMD_SET_ROLLOVER: begin
                            rollover_val[i*NUM_CNT_BITS +: NUM_CNT_BITS] <= cmd_data_q;
                        end
                        timer_bank_pkg::CMD_ENABLE: begin
                            count_enable[i] <= 1'b1;
                        end
                        timer_bank_pkg::CMD_DISABLE: begin
                            count_enable[i] <= 1'b0;
                        end
                        timer_bank_pkg::CMD_SET_MASK: begin
                            irq_mask[i] <= cmd_data_q[0];
                        end
                        default: begin
                            // Pulse commands and NOP leave settings alone
                        end
                    endcase
                end
            end
        end
    end

    // ******************************
    // Single cycle pulses
    // ******************************

    // Pulses last one cycle since they reload every edge
    always_ff @(posedge tb_clk) begin
        if (!rst_n) begin
            clear <= '0;
            ack   <= '0;
        end else begin
            clear <= ch_sel & {NUM_CHANNELS{cmd_op_q == timer_bank_pkg::CMD_CLEAR}};
            ack   <= ch_sel & {NUM_CHANNELS{cmd_op_q == timer_bank_pkg::CMD_ACK}};
        end
    end

endmodule

`default_nettype wire

// File: flex_counter.sv
`timescale 1ns/10ps
`default_nettype none

module flex_counter #(
    parameter int NUM_CNT_BITS = 4
) (
    input  wire logic                    tb_clk,
    input  wire logic                    rst_n,
    input  wire logic                    clear,
    input  wire logic                    count_enable,
    input  wire logic [NUM_CNT_BITS-1:0] rollover_val,
    output logic      [NUM_CNT_BITS-1:0] count_out,
    output logic                         rollover_flag
);

    // Next state of the count and of the flag
    logic [NUM_CNT_BITS-1:0] next_count;
    logic                    next_flag;
    // High when a rollover value is programmed
    logic                    rollover_on;

    // Zero rollover value means free running
    assign rollover_on = (rollover_val != '0);

    // ******************************
    // Next count
    // ******************************
    always_comb begin
        // Hold by default
        next_count = count_out;
        if (clear) begin
            // Clear beats enable
            next_count = '0;
        end else if (count_enable) begin
            if (rollover_on && (count_out == rollover_val)) begin
                // Restart at one after the rollover value
                next_count = NUM_CNT_BITS'(1);
            end else begin
                // Plain increment that wraps through zero
                next_count = count_out + NUM_CNT_BITS'(1);
            end
        end
    end

    // Flag follows the count it will sit next to
    assign next_flag = !clear && count_enable && rollover_on &&
                       (next_count == rollover_val);

    // ******************************
    // State registers
    // ******************************
    always_ff @(posedge tb_clk) begin
        if (!rst_n) begin
            count_out     <= '0;
            rollover_flag <= 1'b0;
        end else begin
            count_out     <= next_count;
            rollover_flag <= next_flag;
        end
    end

endmodule

`default_nettype wire

// File: timer_bank_pkg.sv
`default_nettype none

package timer_bank_pkg;

    // ******************************
    // Command opcodes
    // ******************************

    // Three bit opcode carried on cmd_op
    // Codes are fixed so stimulus can use plain numbers
    typedef enum logic [2:0] {
        // Nothing happens for this command
        CMD_NOP          = 3'd0,
        // Load cmd_data as the rollover value
        CMD_SET_ROLLOVER = 3'd1,
        // Start counting on the channel
        CMD_ENABLE       = 3'd2,
        // Stop counting and hold the count
        CMD_DISABLE      = 3'd3,
        // One cycle clear pulse to the counter
        CMD_CLEAR        = 3'd4,
        // Drop the sticky rollover event
        CMD_ACK          = 3'd5,
        // Interrupt mask bit taken from cmd_data[0]
        CMD_SET_MASK     = 3'd6
    } cmd_op_t;

    // ******************************
    // Read selects
    // ******************************

    // Picks what rd_data shows
    typedef enum logic {
        // Count of the channel on rd_ch
        RD_COUNT  = 1'b0,
        // Sticky event bits, zero extended
        RD_STATUS = 1'b1
    } rd_sel_t;

endpackage

`default_nettype wire
